//--- common/cpu_pkg.sv
package cpu_pkg;

    // opcodes 8..15 are left undefined and execute as no-ops.
    typedef enum logic [3:0] {
        OP_JMP  = 4'd0,
        OP_LOD  = 4'd1,
        OP_STR  = 4'd2,
        OP_ADD  = 4'd3,
        OP_ADDI = 4'd4,
        OP_LODI = 4'd5,
        OP_NAND = 4'd6,
        OP_JEQZ = 4'd7
    } opcode_t;

    // register form: op d s t.
    typedef struct packed {
        logic [3:0] op;
        logic [3:0] d;
        logic [3:0] s;
        logic [3:0] t;
    } r_inst_t;

    // immediate form: op d imm.
    typedef struct packed {
        logic [3:0] op;
        logic [3:0] d;
        logic [7:0] imm;
    } i_inst_t;

    // one instruction word, read through whichever view the opcode calls for.
    typedef union packed {
        r_inst_t r;
        i_inst_t i;
    } inst_t;

    // one client's request to the shared memory bus.
    typedef struct packed {
        logic       req;
        logic       we;
        logic [7:0] addr;
        logic [7:0] wdata;
    } mem_req_t;

    // register file write.
    typedef struct packed {
        logic       we;
        logic [3:0] addr;
        logic [7:0] val;
    } wb_t;

endpackage

//--- logic/mem_arb.sv
module mem_arb import cpu_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  mem_req_t   fetch_bus,
    input  mem_req_t   exec_bus,
    output logic [7:0] addr,
    output logic [7:0] data_out,
    output logic       we,
    output logic       fetch_ready,
    output logic       exec_ready
);

    logic gnt_exec;
    logic gnt_fetch;

    // a client still shows req during its ready cycle, so mask it then.
    assign gnt_exec  = exec_bus.req & ~exec_ready;
    assign gnt_fetch = fetch_bus.req & ~fetch_ready & ~gnt_exec; // exec wins.

    assign addr     = gnt_exec ? exec_bus.addr : fetch_bus.addr;
    assign data_out = gnt_exec ? exec_bus.wdata : 8'h00;
    assign we       = gnt_exec & exec_bus.we;

    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_ready <= 1'b0;
            exec_ready  <= 1'b0;
        end else begin
            fetch_ready <= gnt_fetch; // read data is on data_in now.
            exec_ready  <= gnt_exec;
        end
    end

    a_one_ready: assert property (@(posedge clk) disable iff (rst)
        !(fetch_ready && exec_ready));

endmodule

//--- cpu/reg_file.sv
module reg_file import cpu_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic [3:0] rd_d,
    input  logic [3:0] rd_s,
    input  logic [3:0] rd_t,
    input  wb_t        rf_wr,
    output logic [7:0] rs_d,
    output logic [7:0] rs_s,
    output logic [7:0] rs_t
);

    logic [7:0] regs [16];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= 8'h00;
            end
        end else if (rf_wr.we) begin
            regs[rf_wr.addr] <= rf_wr.val;
        end
    end

    // reads are combinational, a write shows up the cycle after.
    assign rs_d = regs[rd_d];
    assign rs_s = regs[rd_s];
    assign rs_t = regs[rd_t];

endmodule

//--- cpu/fetch.sv
module fetch import cpu_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       fetch_start,
    input  logic [7:0] fetch_pc,
    input  logic [7:0] data_in,
    input  logic       bus_ready,
    output mem_req_t   bus,
    output logic       fetch_done,
    output inst_t      fetch_inst
);

    typedef enum logic [1:0] {
        F_IDLE,
        F_HI,
        F_LO
    } state_t;

    state_t     state;
    logic [7:0] pc_q;
    logic [7:0] hi_q;

    // high byte first, then the low byte at pc+1.
    assign bus.req   = (state != F_IDLE);
    assign bus.we    = 1'b0;
    assign bus.addr  = (state == F_LO) ? pc_q + 8'd1 : pc_q;
    assign bus.wdata = 8'h00;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= F_IDLE;
            fetch_done <= 1'b0;
        end else begin
            fetch_done <= 1'b0;
            case (state)
                F_IDLE: if (fetch_start) state <= F_HI;
                F_HI:   if (bus_ready) state <= F_LO;
                F_LO: begin
                    if (bus_ready) begin
                        fetch_done <= 1'b1;
                        state      <= F_IDLE;
                    end
                end
                default: state <= F_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == F_IDLE && fetch_start) pc_q <= fetch_pc;
        if (state == F_HI && bus_ready) hi_q <= data_in;
        if (state == F_LO && bus_ready) fetch_inst <= {hi_q, data_in}; // held until next start.
    end

    a_start_when_idle: assert property (@(posedge clk) disable iff (rst)
        fetch_start |-> state == F_IDLE);

endmodule

//--- cpu/exec.sv
module exec import cpu_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       exec_start,
    input  inst_t      exec_inst,
    input  logic [7:0] exec_pc,
    input  logic [7:0] rs_d,
    input  logic [7:0] rs_s,
    input  logic [7:0] rs_t,
    input  logic [7:0] data_in,
    input  logic       bus_ready,
    output logic [3:0] rd_d,
    output logic [3:0] rd_s,
    output logic [3:0] rd_t,
    output mem_req_t   bus,
    output logic       exec_done,
    output wb_t        exec_wb,
    output logic       jump_taken,
    output logic [7:0] jump_pc
);

    typedef enum logic {
        X_IDLE,
        X_MEM
    } state_t;

    state_t     state;
    opcode_t    op;
    logic       is_mem;
    wb_t        wb_next;
    logic       take_next;
    logic [7:0] target_next;
    logic       mem_we;
    logic [7:0] mem_addr;
    logic [7:0] mem_wdata;

    assign op     = opcode_t'(exec_inst.r.op);
    assign is_mem = (op == OP_LOD) || (op == OP_STR);
    assign rd_d   = exec_inst.r.d;
    assign rd_s   = exec_inst.r.s;
    assign rd_t   = exec_inst.r.t;

    assign bus.req   = (state == X_MEM);
    assign bus.we    = mem_we;
    assign bus.addr  = mem_addr;
    assign bus.wdata = mem_wdata;

    always_comb begin
        wb_next      = '0;
        wb_next.addr = exec_inst.r.d;
        take_next    = 1'b0;
        target_next  = exec_pc + 8'd2; // fall through.
        case (op)
            OP_JMP: begin
                take_next   = 1'b1;
                target_next = exec_inst.i.imm;
            end
            OP_LOD:  wb_next.we = 1'b1; // value arrives from the bus.
            OP_ADD: begin
                wb_next.we  = 1'b1;
                wb_next.val = rs_s + rs_t;
            end
            OP_ADDI: begin
                wb_next.we  = 1'b1;
                wb_next.val = rs_d + exec_inst.i.imm;
            end
            OP_LODI: begin
                wb_next.we  = 1'b1;
                wb_next.val = exec_inst.i.imm;
            end
            OP_NAND: begin
                wb_next.we  = 1'b1;
                wb_next.val = ~(rs_s & rs_t);
            end
            OP_JEQZ: begin
                take_next   = (rs_d == 8'h00);
                target_next = take_next ? rs_s : target_next;
            end
            default: ; // STR and undefined opcodes write no register.
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= X_IDLE;
            exec_done  <= 1'b0;
            jump_taken <= 1'b0;
        end else begin
            exec_done  <= 1'b0;
            jump_taken <= 1'b0;
            case (state)
                X_IDLE: begin
                    if (exec_start && is_mem) begin
                        state <= X_MEM;
                    end else if (exec_start) begin
                        exec_done  <= 1'b1;
                        jump_taken <= take_next;
                    end
                end
                X_MEM: begin
                    if (bus_ready) begin
                        exec_done <= 1'b1;
                        state     <= X_IDLE;
                    end
                end
                default: state <= X_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == X_IDLE && exec_start) begin
            mem_we    <= (op == OP_STR);
            mem_addr  <= rs_s;
            mem_wdata <= rs_d;
            exec_wb   <= wb_next;
            jump_pc   <= target_next;
        end
        if (state == X_MEM && bus_ready) exec_wb.val <= data_in;
    end

endmodule

//--- cpu/stage_ctrl.sv
module stage_ctrl import cpu_pkg::*; #(
    parameter logic [7:0] RESET_PC = 8'h00
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       fetch_done,
    input  inst_t      fetch_inst,
    input  logic       exec_done,
    input  wb_t        exec_wb,
    input  logic       jump_taken,
    input  logic [7:0] jump_pc,
    output logic       fetch_start,
    output logic [7:0] fetch_pc,
    output logic       exec_start,
    output inst_t      exec_inst,
    output logic [7:0] exec_pc,
    output wb_t        rf_wr
);

    logic [7:0] pc;         // address of the next word to fetch.
    inst_t      ibuf;
    logic [7:0] ibuf_pc;
    logic       ibuf_valid;
    logic       fetch_busy; // the first fetch has been issued.
    logic       fetch_held; // fetch finished but the buffer was full.
    logic       exec_busy;
    logic       flush_pend;

    logic       word_in;
    logic       redirect;
    logic       drop;
    logic       take;

    assign word_in  = fetch_done | fetch_held;
    assign redirect = exec_done & jump_taken;
    assign drop     = word_in & (flush_pend | redirect); // stale word after a jump.
    assign take     = word_in & ~drop & ~ibuf_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc          <= RESET_PC;
            ibuf_valid  <= 1'b0;
            fetch_busy  <= 1'b0;
            fetch_held  <= 1'b0;
            exec_busy   <= 1'b0;
            flush_pend  <= 1'b0;
            fetch_start <= 1'b0;
            exec_start  <= 1'b0;
            rf_wr       <= '0;
        end else begin
            fetch_start <= 1'b0;
            exec_start  <= 1'b0;
            rf_wr       <= exec_done ? exec_wb : '0;
            fetch_held  <= word_in & ~take & ~drop;

            if (!fetch_busy) begin // first fetch after reset.
                fetch_start <= 1'b1;
                fetch_pc    <= pc;
                fetch_busy  <= 1'b1;
            end

            if (take) begin
                ibuf        <= fetch_inst;
                ibuf_pc     <= pc;
                ibuf_valid  <= 1'b1;
                pc          <= pc + 8'd2;
                fetch_start <= 1'b1;
                fetch_pc    <= pc + 8'd2;
            end

            if (drop) begin
                flush_pend  <= 1'b0;
                fetch_start <= 1'b1;
                fetch_pc    <= redirect ? jump_pc : pc;
            end

            // a fetch is always in flight unless its word is here now.
            if (redirect) begin
                pc         <= jump_pc;
                ibuf_valid <= 1'b0;
                flush_pend <= ~word_in;
            end

            // issue from the buffer once the previous writeback is done.
            if (ibuf_valid && !exec_busy && !exec_start) begin
                exec_start <= 1'b1;
                exec_inst  <= ibuf;
                exec_pc    <= ibuf_pc;
                ibuf_valid <= 1'b0;
            end

            if (exec_start) begin
                exec_busy <= 1'b1;
            end else if (exec_done) begin
                exec_busy <= 1'b0;
            end
        end
    end

    a_no_start_while_busy: assert property (@(posedge clk) disable iff (rst)
        exec_start |-> !exec_busy);

endmodule

//--- cpu/eightbit.sv
module eightbit import cpu_pkg::*; #(
    parameter logic [7:0] RESET_PC = 8'h00
) (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] data_in,
    output logic [7:0] addr,
    output logic [7:0] data_out,
    output logic       we
);

    logic       fetch_start;
    logic [7:0] fetch_pc;
    logic       fetch_done;
    inst_t      fetch_inst;

    logic       exec_start;
    inst_t      exec_inst;
    logic [7:0] exec_pc;
    logic       exec_done;
    wb_t        exec_wb;
    logic       jump_taken;
    logic [7:0] jump_pc;

    wb_t        rf_wr;
    logic [3:0] rd_d;
    logic [3:0] rd_s;
    logic [3:0] rd_t;
    logic [7:0] rs_d;
    logic [7:0] rs_s;
    logic [7:0] rs_t;

    mem_req_t   fetch_bus;
    mem_req_t   exec_bus;
    logic       fetch_ready;
    logic       exec_ready;

    stage_ctrl #(
        .RESET_PC(RESET_PC)
    ) u_stage_ctrl (
        .clk(clk),
        .rst(rst),
        .fetch_done(fetch_done),
        .fetch_inst(fetch_inst),
        .exec_done(exec_done),
        .exec_wb(exec_wb),
        .jump_taken(jump_taken),
        .jump_pc(jump_pc),
        .fetch_start(fetch_start),
        .fetch_pc(fetch_pc),
        .exec_start(exec_start),
        .exec_inst(exec_inst),
        .exec_pc(exec_pc),
        .rf_wr(rf_wr)
    );

    fetch u_fetch (
        .clk(clk),
        .rst(rst),
        .fetch_start(fetch_start),
        .fetch_pc(fetch_pc),
        .data_in(data_in),
        .bus_ready(fetch_ready),
        .bus(fetch_bus),
        .fetch_done(fetch_done),
        .fetch_inst(fetch_inst)
    );

    exec u_exec (
        .clk(clk),
        .rst(rst),
        .exec_start(exec_start),
        .exec_inst(exec_inst),
        .exec_pc(exec_pc),
        .rs_d(rs_d),
        .rs_s(rs_s),
        .rs_t(rs_t),
        .data_in(data_in),
        .bus_ready(exec_ready),
        .rd_d(rd_d),
        .rd_s(rd_s),
        .rd_t(rd_t),
        .bus(exec_bus),
        .exec_done(exec_done),
        .exec_wb(exec_wb),
        .jump_taken(jump_taken),
        .jump_pc(jump_pc)
    );

    reg_file u_reg_file (
        .clk(clk),
        .rst(rst),
        .rd_d(rd_d),
        .rd_s(rd_s),
        .rd_t(rd_t),
        .rf_wr(rf_wr),
        .rs_d(rs_d),
        .rs_s(rs_s),
        .rs_t(rs_t)
    );

    mem_arb u_mem_arb (
        .clk(clk),
        .rst(rst),
        .fetch_bus(fetch_bus),
        .exec_bus(exec_bus),
        .addr(addr),
        .data_out(data_out),
        .we(we),
        .fetch_ready(fetch_ready),
        .exec_ready(exec_ready)
    );

endmodule

//--- verif/eightbit_tb.sv
module eightbit_tb;

    localparam int         CLK_PERIOD      = 10;
    localparam int         DRIVE_DELAY     = 1;
    localparam logic [7:0] RESET_PC        = 8'h00;
    localparam logic [7:0] DATA_BASE       = 8'h80;
    localparam logic [7:0] TRAP_BASE       = 8'hF0; // only skipped code stores up here.
    localparam logic [7:0] LOOP_PC         = 8'h4A;
    localparam logic [7:0] PROG_END        = 8'h4C;
    localparam int         N_WORDS         = 38;
    localparam int         WATCHDOG_CYCLES = N_WORDS * 60;
    localparam logic [3:0] N_STORES        = 4'd9;

    // program image from address 0, high byte at the even address.
    localparam logic [15:0] PROG [N_WORDS] = '{
        16'h59F0, 16'h515A, // 00 lodi r9,f0    lodi r1,5a
        16'h5290, 16'h2120, // 04 lodi r2,90    str r1,[r2]
        16'h53C0, 16'h3413, // 08 lodi r3,c0    add r4,r1,r3
        16'h4201, 16'h2420, // 0c addi r2,1     str r4,[r2]
        16'h41F0, 16'h4201, // 10 addi r1,f0    addi r2,1
        16'h2120, 16'h6513, // 14 str r1,[r2]   nand r5,r1,r3
        16'h4201, 16'h2520, // 18 addi r2,1     str r5,[r2]
        16'h5680, 16'h1760, // 1c lodi r6,80    lod r7,[r6]
        16'h4201, 16'h2720, // 20 addi r2,1     str r7,[r2]
        16'h97FF, 16'h4201, // 24 opcode 9      addi r2,1
        16'h2720, 16'h7180, // 28 str r7,[r2]   jeqz r1,r8 (not taken)
        16'h4201, 16'h2120, // 2c addi r2,1     str r1,[r2]
        16'h583A, 16'h7080, // 30 lodi r8,3a    jeqz r0,r8 (taken)
        16'h2190, 16'h2190, // 34 skipped stores to the trap area.
        16'h2190, 16'h4201, // 38 skipped       addi r2,1
        16'h2820, 16'h0046, // 3c str r8,[r2]   jmp 46
        16'h2190, 16'h2190, // 40 skipped
        16'h2190, 16'h4201, // 44 skipped       addi r2,1
        16'h2320, 16'h004A  // 48 str r3,[r2]   jmp 4a
    };

    // {address, value} of every store in program order.
    localparam logic [15:0] EXP_STORE [N_STORES] = '{
        16'h905A, // lodi value.
        16'h911A, // 5a + c0 wraps.
        16'h924A, // 5a + f0 wraps.
        16'h93BF, // ~(4a & c0).
        16'h94C3, // byte loaded from 0x80.
        16'h95C3, // opcode 9 left r7 alone
        16'h964A, // jeqz fell through.
        16'h973A, // jeqz target reached.
        16'h98C0  // jmp target reached.
    };

    logic        clk = 1'b0;
    logic        rst;
    logic [7:0]  data_in;
    logic [7:0]  addr;
    logic [7:0]  data_out;
    logic        we;

    logic [7:0]  mem [256];
    logic [7:0]  bus_addr;
    logic        bus_we;
    logic [7:0]  bus_wdata;
    logic        gnt;
    logic [1:0]  read_cnt;
    logic [1:0]  loop_reads;
    logic [3:0]  store_idx;
    logic [7:0]  boot_addr;
    logic [15:0] exp_now;
    int          errors = 0;

    eightbit #(
        .RESET_PC(RESET_PC)
    ) u_eightbit (
        .clk(clk),
        .rst(rst),
        .data_in(data_in),
        .addr(addr),
        .data_out(data_out),
        .we(we)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // a bus access happens only in a cycle the arbiter grants.
    assign gnt       = u_eightbit.u_mem_arb.gnt_exec | u_eightbit.u_mem_arb.gnt_fetch;
    assign boot_addr = RESET_PC + {6'd0, read_cnt};
    assign exp_now   = (store_idx < N_STORES) ? EXP_STORE[store_idx] : 16'h0000;

    // synchronous memory, write at the grant edge and read data one cycle later.
    always @(posedge clk) begin
        bus_addr  = addr;
        bus_we    = we;
        bus_wdata = data_out;
        #DRIVE_DELAY;
        if (bus_we) mem[bus_addr] = bus_wdata;
        data_in = mem[bus_addr];
    end

    always @(posedge clk) begin
        if (rst) begin
            read_cnt   <= 2'd0;
            loop_reads <= 2'd0;
            store_idx  <= 4'd0;
        end else if (gnt) begin
            if (we && store_idx != 4'hF) store_idx <= store_idx + 4'd1;
            if (!we && read_cnt != 2'd2) read_cnt <= read_cnt + 2'd1;
            if (!we && addr == LOOP_PC && store_idx == N_STORES && loop_reads != 2'd3) begin
                loop_reads <= loop_reads + 2'd1; // idle loop after the last store.
            end
        end
    end

    a_boot_quiet: assert property (@(posedge clk) (rst || read_cnt != 2'd2) |-> !we)
        else begin
            errors++;
            $display("error: we = %h before the first instruction, expected 0", $sampled(we));
        end

    a_first_reads: assert property (@(posedge clk) disable iff (rst)
        (gnt && read_cnt != 2'd2) |-> addr == boot_addr)
        else begin
            errors++;
            $display("error: addr = %h on a boot fetch, expected %h",
                     $sampled(addr), $sampled(boot_addr));
        end

    a_store_known: assert property (@(posedge clk) disable iff (rst)
        we |-> store_idx < N_STORES)
        else begin
            errors++;
            $display("more writes than the expected stores, at address %h", $sampled(addr));
        end

    a_store_addr: assert property (@(posedge clk) disable iff (rst)
        we |-> addr == exp_now[15:8])
        else begin
            errors++;
            $display("error: addr = %h on store %0d, expected %h",
                     $sampled(addr), $sampled(store_idx), $sampled(exp_now[15:8]));
        end

    a_store_data: assert property (@(posedge clk) disable iff (rst)
        we |-> data_out == exp_now[7:0])
        else begin
            errors++;
            $display("error: data_out = %h on store %0d, expected %h",
                     $sampled(data_out), $sampled(store_idx), $sampled(exp_now[7:0]));
        end

    a_no_prog_write: assert property (@(posedge clk) disable iff (rst)
        we |-> addr >= PROG_END)
        else begin
            errors++;
            $display("a write hit the program region at address %h", $sampled(addr));
        end

    a_no_skip_write: assert property (@(posedge clk) disable iff (rst)
        we |-> addr < TRAP_BASE)
        else begin
            errors++;
            $display("an instruction in a skipped region wrote to %h", $sampled(addr));
        end

    task automatic load_image();
        for (int a = 0; a < 256; a++) begin
            mem[a[7:0]] = a[7:0] ^ 8'hA5;
        end
        for (int i = 0; i < N_WORDS; i++) begin
            mem[{i[6:0], 1'b0}] = PROG[i[5:0]][15:8];
            mem[{i[6:0], 1'b1}] = PROG[i[5:0]][7:0];
        end
        mem[DATA_BASE] = 8'hC3;
    endtask

    task automatic finish_with_report(input bit timed_out);
        $display("errors: %0d, stores seen: %0d of %0d", errors, store_idx, N_STORES);
        if (timed_out || errors != 0) begin
            $display("*** TEST FAILED ***");
        end else begin
            $display("*** TEST PASSED ***");
        end
        $finish;
    endtask

    initial begin
        rst     = 1'b1;
        data_in = 8'h00;
        load_image();
        repeat (3) @(posedge clk);
        #DRIVE_DELAY rst = 1'b0;
        wait (loop_reads == 2'd3);
        finish_with_report(1'b0);
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: the program did not finish within %0d cycles", WATCHDOG_CYCLES);
        finish_with_report(1'b1);
    end

endmodule

//--- project.f
common/cpu_pkg.sv
logic/mem_arb.sv
cpu/reg_file.sv
cpu/fetch.sv
cpu/exec.sv
cpu/stage_ctrl.sv
cpu/eightbit.sv
verif/eightbit_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the eightbit testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module eightbit_tb \
    -f project.f -o eightbit_sim

./obj_dir/eightbit_sim | tee sim.log

if grep -qF '*** TEST FAILED ***' sim.log; then
    exit 1
fi
exit 0
